/* hdl/conv_ctrl_pkg.sv */
`default_nettype none

package conv_ctrl_pkg;

  // feature map geometry, in 16-pixel words
  localparam int FMAP_H = 4;
  localparam int X_WORDS = 2;
  localparam int IN_CH = 4;
  localparam int OUT_GROUPS = 2;
  localparam int KERNEL = 3;
  localparam int OUTS_PER_GROUP = 16;

  // memory sizes
  localparam int WEIGHT_WORDS = KERNEL * KERNEL * IN_CH * OUT_GROUPS;
  localparam int ACT_WORDS = FMAP_H * X_WORDS * IN_CH;
  localparam int OUT_WORDS = FMAP_H * X_WORDS * OUT_GROUPS * OUTS_PER_GROUP;

  // outputs live in the upper half of the activation memory
  localparam int OUTPUT_BASE = 256;

  localparam int W_ADDR_W = $clog2(WEIGHT_WORDS);
  localparam int ACT_ADDR_W = $clog2(OUTPUT_BASE + OUT_WORDS);

  // activation address, loaded as a flat count and read back by field
  typedef union packed {
    logic [ACT_ADDR_W-1:0] flat;
    struct packed {
      // zero for the activation region
      logic [3:0] region;
      logic [1:0] row;
      logic       col;
      logic [1:0] ch;
    } fields;
  } act_addr_u;

endpackage

`default_nettype wire

/* hdl/conv_ctrl_ifs.sv */
`default_nettype none

// load control between sequencer, loader and writeback
interface load_if;
  import conv_ctrl_pkg::*;

  logic      load_weights;
  logic      load_acts;
  logic      weights_done;
  logic      acts_done;
  logic      act_wr_strobe;
  act_addr_u act_wr_addr;

  modport seq (
    output load_weights, load_acts,
    input  weights_done, acts_done
  );

  modport ldr (
    input  load_weights, load_acts,
    output weights_done, acts_done, act_wr_strobe, act_wr_addr
  );

  // writeback only muxes the loader's write onto the memory port
  modport wb (
    input act_wr_strobe, act_wr_addr
  );
endinterface

// compute reads, output burst and drain control
interface wb_if;
  import conv_ctrl_pkg::*;

  logic      rd_strobe;
  act_addr_u rd_addr;
  logic      out_write;
  logic      burst_last;
  logic      drain;
  logic      drain_done;

  modport seq (
    output rd_strobe, rd_addr, out_write, drain,
    input  burst_last, drain_done
  );

  modport wb (
    input  rd_strobe, rd_addr, out_write, drain,
    output burst_last, drain_done
  );
endinterface

`default_nettype wire

/* hdl/conv_loader.sv */
`default_nettype none

module conv_loader (
  input  logic                            clk,
  input  logic                            arst_n_in,
  input  logic                            weights_valid,
  input  logic                            activations_valid,
  output logic                            weights_ready,
  output logic                            activations_ready,
  output logic                            weights_mem_wr_n,
  output logic [conv_ctrl_pkg::W_ADDR_W-1:0] weights_addr,
  load_if.ldr                             ld
);
  import conv_ctrl_pkg::*;

  // channel 0 loads weights, channel 1 loads activations
  for (genvar i = 0; i < 2; i++) begin : g_ch
    logic                  go;
    logic                  vld;
    logic                  busy;
    logic                  beat;
    logic                  last;
    logic [ACT_ADDR_W-1:0] cnt;

    assign go   = (i == 0) ? ld.load_weights : ld.load_acts;
    assign vld  = (i == 0) ? weights_valid : activations_valid;
    assign beat = busy && vld;
    assign last = cnt == ACT_ADDR_W'((i == 0) ? WEIGHT_WORDS - 1 : ACT_WORDS - 1);

    always_ff @(posedge clk or negedge arst_n_in) begin
      if (!arst_n_in) begin
        busy <= 1'b0;
        cnt  <= '0;
      end else if (beat && last) begin
        // back to address 0 for the next run
        busy <= 1'b0;
        cnt  <= '0;
      end else begin
        if (go && !busy) begin
          busy <= 1'b1;
        end
        // address holds while valid is low
        if (beat) begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  assign weights_ready     = g_ch[0].busy;
  assign activations_ready = g_ch[1].busy;

  // weight memory write, active low
  assign weights_mem_wr_n = !g_ch[0].beat;
  assign weights_addr     = g_ch[0].cnt[W_ADDR_W-1:0];

  assign ld.weights_done  = g_ch[0].beat && g_ch[0].last;
  assign ld.acts_done     = g_ch[1].beat && g_ch[1].last;
  assign ld.act_wr_strobe = g_ch[1].beat;
  assign ld.act_wr_addr   = g_ch[1].cnt;

endmodule

`default_nettype wire

/* hdl/conv_sequencer.sv */
`default_nettype none

module conv_sequencer (
  input  logic                               clk,
  input  logic                               arst_n_in,
  input  logic                               start,
  output logic                               running,
  output logic                               weights_mem_rd_n,
  output logic [conv_ctrl_pkg::W_ADDR_W-1:0] weights_rd_addr,
  output logic                               write_weights_registers,
  output logic                               write_act_registers_first,
  output logic                               write_act_registers_second,
  output logic                               shift,
  output logic                               mac_valid,
  output logic                               mac_accumulate,
  load_if.seq                                ld,
  wb_if.seq                                  wb
);
  import conv_ctrl_pkg::*;

  enum logic [3:0] {
    IDLE, LOAD_W, LOAD_A, LOAD, FETCH, MAC0_SHIFT1, FETCH1_LOAD2, MAC1_FETCH2,
    SHIFT2, MAC2, DUMMY1, DUMMY2, DUMMY3, WRITE_OUT, DRAIN
  } state, state_nxt;

  // loop nest, outermost first
  logic [$clog2(FMAP_H)-1:0]     y;
  logic [$clog2(X_WORDS)-1:0]    x;
  logic [$clog2(OUT_GROUPS)-1:0] ch_out;
  logic [$clog2(IN_CH)-1:0]      ch_in;
  logic [$clog2(KERNEL)-1:0]     k_v;
  logic [$clog2(KERNEL)-1:0]     k_h;
  logic [$clog2(KERNEL)-1:0]     kv_nxt;
  logic last_y, last_x, last_ch_out, last_ch_in, last_k_v, last_k_h;

  logic      mac_int;
  logic      dummy;
  logic      w_ce;
  logic      second_word;
  logic      dummy_now;
  logic      dummy_next;
  logic      group_end;
  logic      all_done;
  act_addr_u rd_addr;

  assign last_y      = int'(y) == FMAP_H - 1;
  assign last_x      = int'(x) == X_WORDS - 1;
  assign last_ch_out = int'(ch_out) == OUT_GROUPS - 1;
  assign last_ch_in  = int'(ch_in) == IN_CH - 1;
  assign last_k_v    = int'(k_v) == KERNEL - 1;
  assign last_k_h    = int'(k_h) == KERNEL - 1;
  assign kv_nxt      = last_k_v ? '0 : k_v + 1'b1;

  // padding rows above the first and below the last feature map row
  assign dummy_now  = (y == '0 && k_v == '0) || (last_y && last_k_v);
  assign dummy_next = (y == '0 && kv_nxt == '0) || (last_y && int'(kv_nxt) == KERNEL - 1);
  assign group_end  = last_ch_in && last_k_v;
  // the loop nest has wrapped back to its origin
  assign all_done   = y == '0 && x == '0 && ch_out == '0;

  assign running   = state != IDLE;
  assign mac_valid = mac_int && !dummy;
  assign mac_accumulate = !((ch_in == '0 && k_v == '0 && k_h == '0) ||
                            (y == '0 && ch_in == '0 && int'(k_v) == 1 && k_h == '0));

  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // counters chained on every mac, real or dummy
  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      y      <= '0;
      x      <= '0;
      ch_out <= '0;
      ch_in  <= '0;
      k_v    <= '0;
      k_h    <= '0;
    end else if (mac_int) begin
      k_h <= last_k_h ? '0 : k_h + 1'b1;
      if (last_k_h) begin
        k_v <= kv_nxt;
        if (last_k_v) begin
          ch_in <= last_ch_in ? '0 : ch_in + 1'b1;
          if (last_ch_in) begin
            ch_out <= last_ch_out ? '0 : ch_out + 1'b1;
            if (last_ch_out) begin
              x <= last_x ? '0 : x + 1'b1;
              if (last_x) begin
                y <= last_y ? '0 : y + 1'b1;
              end
            end
          end
        end
      end
    end
  end

  // weight read address, wraps once per output word pair
  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      weights_rd_addr <= '0;
    end else if (w_ce) begin
      weights_rd_addr <= (int'(weights_rd_addr) == WEIGHT_WORDS - 1) ? '0
                                                                      : weights_rd_addr + 1'b1;
    end
  end

  // row is offset by one for the padding row on top
  always_comb begin
    rd_addr.fields.region = '0;
    rd_addr.fields.row    = y + k_v - 1'b1;
    rd_addr.fields.col    = second_word ? x + 1'b1 : x;
    rd_addr.fields.ch     = ch_in;
  end
  assign wb.rd_addr = rd_addr;

  always_comb begin
    state_nxt                  = state;
    mac_int                    = 1'b0;
    dummy                      = 1'b0;
    w_ce                       = 1'b0;
    second_word                = 1'b0;
    weights_mem_rd_n           = 1'b1;
    write_weights_registers    = 1'b0;
    write_act_registers_first  = 1'b0;
    write_act_registers_second = 1'b0;
    shift                      = 1'b0;
    ld.load_weights            = 1'b0;
    ld.load_acts               = 1'b0;
    wb.rd_strobe               = 1'b0;
    wb.out_write               = 1'b0;
    wb.drain                   = 1'b0;
    case (state)
      IDLE: begin
        if (start) begin
          state_nxt = LOAD_W;
        end
      end
      LOAD_W: begin
        ld.load_weights = 1'b1;
        if (ld.weights_done) begin
          state_nxt = LOAD_A;
        end
      end
      LOAD_A: begin
        ld.load_acts = 1'b1;
        if (ld.acts_done) begin
          state_nxt = dummy_now ? DUMMY1 : LOAD;
        end
      end
      LOAD: begin
        weights_mem_rd_n = 1'b0;
        w_ce             = 1'b1;
        wb.rd_strobe     = 1'b1;
        state_nxt        = FETCH;
      end
      FETCH: begin
        write_act_registers_first = 1'b1;
        write_weights_registers   = 1'b1;
        state_nxt                 = MAC0_SHIFT1;
      end
      MAC0_SHIFT1: begin
        mac_int                    = 1'b1;
        shift                      = 1'b1;
        write_act_registers_first  = 1'b1;
        write_act_registers_second = 1'b1;
        weights_mem_rd_n           = 1'b0;
        w_ce                       = 1'b1;
        state_nxt                  = FETCH1_LOAD2;
      end
      FETCH1_LOAD2: begin
        weights_mem_rd_n        = 1'b0;
        w_ce                    = 1'b1;
        write_weights_registers = 1'b1;
        // next column word, none past the right edge
        second_word             = 1'b1;
        wb.rd_strobe            = !last_x;
        state_nxt               = MAC1_FETCH2;
      end
      MAC1_FETCH2: begin
        mac_int                    = 1'b1;
        write_act_registers_second = 1'b1;
        write_weights_registers    = 1'b1;
        state_nxt                  = SHIFT2;
      end
      SHIFT2: begin
        shift                      = 1'b1;
        write_act_registers_first  = 1'b1;
        write_act_registers_second = 1'b1;
        state_nxt                  = MAC2;
      end
      MAC2: begin
        mac_int   = 1'b1;
        state_nxt = group_end ? WRITE_OUT : (dummy_next ? DUMMY1 : LOAD);
      end
      DUMMY1, DUMMY2: begin
        mac_int   = 1'b1;
        dummy     = 1'b1;
        w_ce      = 1'b1;
        state_nxt = (state == DUMMY1) ? DUMMY2 : DUMMY3;
      end
      DUMMY3: begin
        mac_int   = 1'b1;
        dummy     = 1'b1;
        w_ce      = 1'b1;
        state_nxt = group_end ? WRITE_OUT : (dummy_next ? DUMMY1 : LOAD);
      end
      WRITE_OUT: begin
        wb.out_write = 1'b1;
        if (wb.burst_last) begin
          state_nxt = all_done ? DRAIN : (dummy_now ? DUMMY1 : LOAD);
        end
      end
      DRAIN: begin
        wb.drain = 1'b1;
        if (wb.drain_done) begin
          state_nxt = IDLE;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/conv_writeback.sv */
`default_nettype none

module conv_writeback (
  input  logic                                 clk,
  input  logic                                 arst_n_in,
  output logic                                 act_mem_wr_n,
  output logic                                 act_mem_rd_n,
  output logic [conv_ctrl_pkg::ACT_ADDR_W-1:0] act_wr_addr,
  output logic [conv_ctrl_pkg::ACT_ADDR_W-1:0] act_rd_addr,
  output logic                                 outputs_to_memory_flag,
  output logic                                 output_valid,
  load_if.wb                                   ld,
  wb_if.wb                                     wb
);
  import conv_ctrl_pkg::*;

  logic [ACT_ADDR_W-1:0] out_addr;
  logic [ACT_ADDR_W-1:0] drain_addr;
  logic [ACT_ADDR_W-1:0] last_out;

  // wraps to zero after the final output, so compare modulo
  assign last_out = out_addr - 1'b1;

  assign wb.burst_last = wb.out_write && (&out_addr[$clog2(OUTS_PER_GROUP)-1:0]);
  assign wb.drain_done = wb.drain && (drain_addr == last_out);

  // output write pointer
  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      out_addr <= ACT_ADDR_W'(OUTPUT_BASE);
    end else if (wb.drain_done) begin
      out_addr <= ACT_ADDR_W'(OUTPUT_BASE);
    end else if (wb.out_write) begin
      out_addr <= out_addr + 1'b1;
    end
  end

  // monitor read pointer, one word per drain cycle
  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      drain_addr <= ACT_ADDR_W'(OUTPUT_BASE);
    end else if (wb.drain_done) begin
      drain_addr <= ACT_ADDR_W'(OUTPUT_BASE);
    end else if (wb.drain) begin
      drain_addr <= drain_addr + 1'b1;
    end
  end

  // read data is on the memory output one cycle later
  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      output_valid <= 1'b0;
    end else begin
      output_valid <= wb.drain;
    end
  end

  // loads and output bursts never overlap
  assign act_mem_wr_n = !(ld.act_wr_strobe || wb.out_write);
  assign act_wr_addr  = wb.out_write ? out_addr : ld.act_wr_addr.flat;

  assign act_mem_rd_n = !(wb.rd_strobe || wb.drain);
  assign act_rd_addr  = wb.drain ? drain_addr : wb.rd_addr.flat;

  assign outputs_to_memory_flag = wb.out_write;

endmodule

`default_nettype wire

/* hdl/conv_ctrl_top.sv */
`default_nettype none

module conv_ctrl_top (
  input  logic                                 clk,
  input  logic                                 arst_n_in,
  input  logic                                 start,
  input  logic                                 weights_valid,
  input  logic                                 activations_valid,
  output logic                                 running,
  output logic                                 weights_ready,
  output logic                                 activations_ready,
  // weight memory
  output logic                                 weights_mem_wr_n,
  output logic                                 weights_mem_rd_n,
  output logic [conv_ctrl_pkg::W_ADDR_W-1:0]   weights_addr,
  output logic [conv_ctrl_pkg::W_ADDR_W-1:0]   weights_rd_addr,
  // activation memory
  output logic                                 act_mem_wr_n,
  output logic                                 act_mem_rd_n,
  output logic [conv_ctrl_pkg::ACT_ADDR_W-1:0] act_wr_addr,
  output logic [conv_ctrl_pkg::ACT_ADDR_W-1:0] act_rd_addr,
  // datapath strobes
  output logic                                 write_weights_registers,
  output logic                                 write_act_registers_first,
  output logic                                 write_act_registers_second,
  output logic                                 shift,
  output logic                                 mac_valid,
  output logic                                 mac_accumulate,
  output logic                                 outputs_to_memory_flag,
  output logic                                 output_valid
);

  load_if ld_bus ();
  wb_if   wb_bus ();

  conv_loader loader_i (
    .clk               (clk),
    .arst_n_in         (arst_n_in),
    .weights_valid     (weights_valid),
    .activations_valid (activations_valid),
    .weights_ready     (weights_ready),
    .activations_ready (activations_ready),
    .weights_mem_wr_n  (weights_mem_wr_n),
    .weights_addr      (weights_addr),
    .ld                (ld_bus.ldr)
  );

  conv_sequencer sequencer_i (
    .clk                        (clk),
    .arst_n_in                  (arst_n_in),
    .start                      (start),
    .running                    (running),
    .weights_mem_rd_n           (weights_mem_rd_n),
    .weights_rd_addr            (weights_rd_addr),
    .write_weights_registers    (write_weights_registers),
    .write_act_registers_first  (write_act_registers_first),
    .write_act_registers_second (write_act_registers_second),
    .shift                      (shift),
    .mac_valid                  (mac_valid),
    .mac_accumulate             (mac_accumulate),
    .ld                         (ld_bus.seq),
    .wb                         (wb_bus.seq)
  );

  conv_writeback writeback_i (
    .clk                    (clk),
    .arst_n_in              (arst_n_in),
    .act_mem_wr_n           (act_mem_wr_n),
    .act_mem_rd_n           (act_mem_rd_n),
    .act_wr_addr            (act_wr_addr),
    .act_rd_addr            (act_rd_addr),
    .outputs_to_memory_flag (outputs_to_memory_flag),
    .output_valid           (output_valid),
    .ld                     (ld_bus.wb),
    .wb                     (wb_bus.wb)
  );

endmodule

`default_nettype wire

/* dv/conv_ctrl_chk.sv */
`default_nettype none

module conv_ctrl_chk (
  input logic                                 clk,
  input logic                                 arst_n_in,
  input logic                                 start,
  input logic                                 weights_valid,
  input logic                                 activations_valid,
  input logic                                 running,
  input logic                                 weights_ready,
  input logic                                 activations_ready,
  input logic                                 weights_mem_wr_n,
  input logic                                 weights_mem_rd_n,
  input logic [conv_ctrl_pkg::W_ADDR_W-1:0]   weights_addr,
  input logic [conv_ctrl_pkg::W_ADDR_W-1:0]   weights_rd_addr,
  input logic                                 act_mem_wr_n,
  input logic                                 act_mem_rd_n,
  input logic [conv_ctrl_pkg::ACT_ADDR_W-1:0] act_wr_addr,
  input logic [conv_ctrl_pkg::ACT_ADDR_W-1:0] act_rd_addr,
  input logic                                 write_weights_registers,
  input logic                                 write_act_registers_first,
  input logic                                 write_act_registers_second,
  input logic                                 shift,
  input logic                                 mac_valid,
  input logic                                 mac_accumulate,
  input logic                                 outputs_to_memory_flag,
  input logic                                 output_valid
);
  import conv_ctrl_pkg::*;

  // real kernel rows give 3 macs each and padding rows none
  localparam int MAC_PULSES = FMAP_H * X_WORDS * OUT_GROUPS * IN_CH * KERNEL * KERNEL -
                              2 * X_WORDS * OUT_GROUPS * IN_CH * KERNEL;

  int        error_count = 0;
  int        w_beats;
  int        a_beats;
  int        o_writes;
  int        d_reads;
  int        mac_count;
  int        ov_count;
  int        w_reads;
  int        grp;
  int        y_m;
  int        x_m;
  int        rows_per_ch;
  int        ch_in_m;
  int        k_v_m;
  int        k_h_m;
  int        w_rd_exp;
  int        rd_exp;
  logic      started;
  logic      first_mac;
  logic      w_beat;
  logic      a_beat;
  logic      w_rd;
  logic      drain_rd;
  logic      compute_rd;
  logic      idle_ok;

  assign w_beat     = weights_ready && weights_valid;
  assign a_beat     = activations_ready && activations_valid;
  assign w_rd       = !weights_mem_rd_n;
  // all outputs written means the remaining reads are the drain
  assign drain_rd   = !act_mem_rd_n && o_writes == OUT_WORDS;
  assign compute_rd = !act_mem_rd_n && o_writes < OUT_WORDS;

  assign idle_ok = !running && !weights_ready && !activations_ready && !mac_valid && !shift &&
                   !write_weights_registers && !write_act_registers_first &&
                   !write_act_registers_second && !outputs_to_memory_flag && !output_valid &&
                   weights_mem_wr_n && weights_mem_rd_n && act_mem_wr_n && act_mem_rd_n;

  // loop nest position from the groups written and the weight reads of this group
  always_comb begin
    grp         = o_writes / OUTS_PER_GROUP;
    y_m         = grp / (X_WORDS * OUT_GROUPS);
    x_m         = (grp / OUT_GROUPS) % X_WORDS;
    // top and bottom rows lose one kernel row to padding
    rows_per_ch = (y_m == 0 || y_m == FMAP_H - 1) ? KERNEL - 1 : KERNEL;
    ch_in_m     = w_reads / KERNEL / rows_per_ch;
    k_v_m       = (w_reads / KERNEL) % rows_per_ch + ((y_m == 0) ? 1 : 0);
    k_h_m       = w_reads % KERNEL;
    // padding rows use up weight addresses too
    w_rd_exp    = (grp * KERNEL * KERNEL * IN_CH + (ch_in_m * KERNEL + k_v_m) * KERNEL +
                   k_h_m) % WEIGHT_WORDS;
    // second column word is read with the third weight
    rd_exp      = ((y_m + k_v_m - 1) * X_WORDS + x_m + ((k_h_m == 0) ? 0 : 1)) * IN_CH +
                  ch_in_m;
  end

  // reference counts of what the DUT has done so far
  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      started   <= 1'b0;
      first_mac <= 1'b1;
      w_beats   <= 0;
      a_beats   <= 0;
      o_writes  <= 0;
      d_reads   <= 0;
      mac_count <= 0;
      ov_count  <= 0;
      w_reads   <= 0;
    end else begin
      started   <= started || start;
      // each output group starts without accumulation
      first_mac <= outputs_to_memory_flag || (first_mac && !mac_valid);
      w_beats   <= w_beats + int'(w_beat);
      a_beats   <= a_beats + int'(a_beat);
      o_writes  <= o_writes + int'(outputs_to_memory_flag);
      d_reads   <= d_reads + int'(drain_rd);
      mac_count <= mac_count + int'(mac_valid);
      ov_count  <= ov_count + int'(output_valid);
      w_reads   <= outputs_to_memory_flag ? 0 : w_reads + int'(w_rd);
    end
  end

  idle_a: assert property (@(posedge clk) disable iff (!arst_n_in)
      !started |-> idle_ok)
    else begin
      error_count++;
      $error("control output or memory enable active before start");
    end

  w_wr_a: assert property (@(posedge clk) disable iff (!arst_n_in)
      weights_mem_wr_n == !w_beat)
    else begin
      error_count++;
      $error("mismatch weights_mem_wr_n: got %h, expected %h",
             $sampled(weights_mem_wr_n), !$sampled(w_beat));
    end

  w_addr_a: assert property (@(posedge clk) disable iff (!arst_n_in)
      w_beat |-> weights_addr == W_ADDR_W'(w_beats))
    else begin
      error_count++;
      $error("mismatch weights_addr: got %h, expected %h",
             $sampled(weights_addr), $sampled(w_beats));
    end

  w_done_a: assert property (@(posedge clk) disable iff (!arst_n_in)
      $fell(weights_ready) |-> w_beats == WEIGHT_WORDS)
    else begin
      error_count++;
      $error("mismatch weights_ready beats: got %h, expected %h",
             $sampled(w_beats), WEIGHT_WORDS);
    end

  a_wr_a: assert property (@(posedge clk) disable iff (!arst_n_in)
      activations_ready |-> act_mem_wr_n == !activations_valid)
    else begin
      error_count++;
      $error("mismatch act_mem_wr_n: got %h, expected %h",
             $sampled(act_mem_wr_n), !$sampled(activations_valid));
    end

  a_addr_a: assert property (@(posedge clk) disable iff (!arst_n_in)
      a_beat |-> act_wr_addr == ACT_ADDR_W'(a_beats))
    else begin
      error_count++;
      $error("mismatch act_wr_addr: got %h, expected %h",
             $sampled(act_wr_addr), $sampled(a_beats));
    end

  a_done_a: assert property (@(posedge clk) disable iff (!arst_n_in)
      $fell(activations_ready) |-> a_beats == ACT_WORDS)
    else begin
      error_count++;
      $error("mismatch activations_ready beats: got %h, expected %h",
             $sampled(a_beats), ACT_WORDS);
    end

  w_rd_addr_a: assert property (@(posedge clk) disable iff (!arst_n_in)
      w_rd |-> weights_rd_addr == W_ADDR_W'(w_rd_exp))
    else begin
      error_count++;
      $error("mismatch weights_rd_addr: got %h, expected %h",
             $sampled(weights_rd_addr), $sampled(w_rd_exp));
    end

  acc_a: assert property (@(posedge clk) disable iff (!arst_n_in)
      mac_valid |-> mac_accumulate == !first_mac)
    else begin
      error_count++;
      $error("mismatch mac_accumulate: got %h, expected %h",
             $sampled(mac_accumulate), !$sampled(first_mac));
    end

  out_flag_a: assert property (@(posedge clk) disable iff (!arst_n_in)
      !activations_ready |-> outputs_to_memory_flag == !act_mem_wr_n)
    else begin
      error_count++;
      $error("mismatch outputs_to_memory_flag: got %h, expected %h",
             $sampled(outputs_to_memory_flag), !$sampled(act_mem_wr_n));
    end

  out_addr_a: assert property (@(posedge clk) disable iff (!arst_n_in)
      outputs_to_memory_flag |-> act_wr_addr == ACT_ADDR_W'(OUTPUT_BASE + o_writes))
    else begin
      error_count++;
      $error("mismatch act_wr_addr: got %h, expected %h",
             $sampled(act_wr_addr), OUTPUT_BASE + $sampled(o_writes));
    end

  // region 0 and the feature map row the loop nest points at
  rd_field_a: assert property (@(posedge clk) disable iff (!arst_n_in)
      compute_rd |-> act_rd_addr == ACT_ADDR_W'(rd_exp))
    else begin
      error_count++;
      $error("mismatch act_rd_addr: got %h, expected %h",
             $sampled(act_rd_addr), $sampled(rd_exp));
    end

  drain_addr_a: assert property (@(posedge clk) disable iff (!arst_n_in)
      drain_rd |-> act_rd_addr == ACT_ADDR_W'(OUTPUT_BASE + d_reads))
    else begin
      error_count++;
      $error("mismatch act_rd_addr: got %h, expected %h",
             $sampled(act_rd_addr), OUTPUT_BASE + $sampled(d_reads));
    end

  // memory read data one cycle after the drain read
  ov_a: assert property (@(posedge clk) disable iff (!arst_n_in)
      output_valid == $past(drain_rd))
    else begin
      error_count++;
      $error("mismatch output_valid: got %h, expected %h",
             $sampled(output_valid), !$sampled(output_valid));
    end

  mac_total_a: assert property (@(posedge clk) disable iff (!arst_n_in)
      $fell(running) |-> mac_count == MAC_PULSES)
    else begin
      error_count++;
      $error("mismatch mac_valid pulses: got %h, expected %h",
             $sampled(mac_count), MAC_PULSES);
    end

  // the last output_valid is still high when running is seen low
  ov_total_a: assert property (@(posedge clk) disable iff (!arst_n_in)
      $fell(running) |-> ov_count + int'(output_valid) == OUT_WORDS)
    else begin
      error_count++;
      $error("mismatch output_valid pulses: got %h, expected %h",
             $sampled(ov_count) + int'($sampled(output_valid)), OUT_WORDS);
    end

  wr_total_a: assert property (@(posedge clk) disable iff (!arst_n_in)
      $fell(running) |-> o_writes == OUT_WORDS && d_reads == OUT_WORDS)
    else begin
      error_count++;
      $error("mismatch output writes and drain reads: got %h and %h, expected %h",
             $sampled(o_writes), $sampled(d_reads), OUT_WORDS);
    end

endmodule

bind conv_ctrl_top conv_ctrl_chk chk_i (
  .clk                        (clk),
  .arst_n_in                  (arst_n_in),
  .start                      (start),
  .weights_valid              (weights_valid),
  .activations_valid          (activations_valid),
  .running                    (running),
  .weights_ready              (weights_ready),
  .activations_ready          (activations_ready),
  .weights_mem_wr_n           (weights_mem_wr_n),
  .weights_mem_rd_n           (weights_mem_rd_n),
  .weights_addr               (weights_addr),
  .weights_rd_addr            (weights_rd_addr),
  .act_mem_wr_n               (act_mem_wr_n),
  .act_mem_rd_n               (act_mem_rd_n),
  .act_wr_addr                (act_wr_addr),
  .act_rd_addr                (act_rd_addr),
  .write_weights_registers    (write_weights_registers),
  .write_act_registers_first  (write_act_registers_first),
  .write_act_registers_second (write_act_registers_second),
  .shift                      (shift),
  .mac_valid                  (mac_valid),
  .mac_accumulate             (mac_accumulate),
  .outputs_to_memory_flag     (outputs_to_memory_flag),
  .output_valid               (output_valid)
);

`default_nettype wire

/* dv/conv_ctrl_tb.sv */
`default_nettype none

module conv_ctrl_tb;
  import conv_ctrl_pkg::*;

  localparam int CLK_PERIOD = 100;
  // 7 cycles per real kernel row, 3 per padding row, plus the output bursts
  localparam int COMPUTE_CYCLES = X_WORDS * OUT_GROUPS * IN_CH *
                                  ((FMAP_H * KERNEL - 2) * 7 + 2 * 3) + OUT_WORDS;
  localparam int WATCHDOG_CYCLES = 20 * (WEIGHT_WORDS + ACT_WORDS + COMPUTE_CYCLES + OUT_WORDS);

  logic                  clk;
  logic                  arst_n_in;
  logic                  start;
  logic                  weights_valid;
  logic                  activations_valid;
  logic                  running;
  logic                  weights_ready;
  logic                  activations_ready;
  logic                  weights_mem_wr_n;
  logic                  weights_mem_rd_n;
  logic [W_ADDR_W-1:0]   weights_addr;
  logic [W_ADDR_W-1:0]   weights_rd_addr;
  logic                  act_mem_wr_n;
  logic                  act_mem_rd_n;
  logic [ACT_ADDR_W-1:0] act_wr_addr;
  logic [ACT_ADDR_W-1:0] act_rd_addr;
  logic                  write_weights_registers;
  logic                  write_act_registers_first;
  logic                  write_act_registers_second;
  logic                  shift;
  logic                  mac_valid;
  logic                  mac_accumulate;
  logic                  outputs_to_memory_flag;
  logic                  output_valid;

  conv_ctrl_top dut_i (.*);

  // 16-bit Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("Finished with errors");
    $fatal(1, "%s", reason);
  endtask

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // one fresh LFSR bit per valid, so both sides stall irregularly
  initial begin : valid_gen
    logic [15:0] lfsr;
    lfsr              = 16'd75;
    weights_valid     = 1'b0;
    activations_valid = 1'b0;
    forever begin
      @(posedge clk);
      lfsr = lfsr_next(lfsr);
      weights_valid <= lfsr[0];
      lfsr = lfsr_next(lfsr);
      activations_valid <= lfsr[0];
    end
  end

  // a failed assertion in the checker ends the run
  always @(negedge clk) begin
    if (dut_i.chk_i.error_count != 0) begin
      stop_with_failure("checker assertion failed");
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_with_failure("timeout, running did not fall within the expected time");
  end

  initial begin : main
    arst_n_in = 1'b0;
    start     = 1'b0;
    repeat (8) @(posedge clk);
    arst_n_in <= 1'b1;
    repeat (2) @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    wait (running);
    wait (!running);
    // let the end-of-run assertions sample the fall of running
    repeat (3) @(posedge clk);
    if (dut_i.chk_i.error_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      stop_with_failure("checker reported errors at the end of the run");
    end
  end

endmodule

`default_nettype wire

/* conv_ctrl.f */
hdl/conv_ctrl_pkg.sv
hdl/conv_ctrl_ifs.sv
hdl/conv_loader.sv
hdl/conv_sequencer.sv
hdl/conv_writeback.sv
hdl/conv_ctrl_top.sv
dv/conv_ctrl_chk.sv
dv/conv_ctrl_tb.sv

/* Makefile */
TOP := conv_ctrl_tb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f conv_ctrl.f
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

.PHONY: sim clean
